//--- hdl/or1420Ci_params.svh
`ifndef OR1420CI_PARAMS_SVH
`define OR1420CI_PARAMS_SVH

// width of custom-instruction operands and results.
`define CI_WORD_WIDTH 32

// width of the custom-instruction number driven by the processor.
`define CI_ID_WIDTH 8

// instruction numbers as assigned on the single-core system.
`define CI_SWAP_BYTE_NR 1
`define CI_PROFILE_NR 11
`define CI_GRAYSCALE_NR 12

// the top bit of the reset counter releases reset, giving sixteen clocks after lock.
`define RESET_COUNT_WIDTH 5

// number of profiling cycle counters.
`define PROFILE_COUNTERS 4

`endif

//--- hdl/ciPkg.sv
`default_nettype none

`include "or1420Ci_params.svh"

package ciPkg;

  // One operand or result word.
  typedef logic [`CI_WORD_WIDTH-1:0] ciWordT;

  typedef enum logic [`CI_ID_WIDTH-1:0] {
    swapByteId  = `CI_ID_WIDTH'(`CI_SWAP_BYTE_NR),
    profileId   = `CI_ID_WIDTH'(`CI_PROFILE_NR),
    grayscaleId = `CI_ID_WIDTH'(`CI_GRAYSCALE_NR)
  } ciIdE;

  // taken from bit 0 of operand B of the byte-swap instruction.
  typedef enum logic {
    fullReverse  = 1'b0,
    halfwordSwap = 1'b1
  } swapModeE;

endpackage

`default_nettype wire

//--- hdl/profilePkg.sv
`default_nettype none

`include "or1420Ci_params.svh"

package profilePkg;

  // selects the counter that a profile read returns (operand A bits 1:0).
  typedef enum logic [1:0] {
    totalCycles   = 2'd0,
    stallCycles   = 2'd1,
    busIdleCycles = 2'd2,
    activeCycles  = 2'd3
  } profCounterE;

  // Control fields in operand B carry one bit per counter in each nibble.
  typedef struct packed {
    logic [`PROFILE_COUNTERS-1:0] clearMask;   // bits 11:8.
    logic [`PROFILE_COUNTERS-1:0] disableMask; // bits 7:4.
    logic [`PROFILE_COUNTERS-1:0] enableMask;  // bits 3:0.
  } profCtrlT;

endpackage

`default_nettype wire

//--- hdl/resetSequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "or1420Ci_params.svh"

module resetSequencer (
  input wire   s_systemClock,
  input wire   s_pllLocked,
  input wire   memoryInitBusy,
  output logic systemReset,
  output logic peripheralResetN,
  output logic ciReset
);

  logic [`RESET_COUNT_WIDTH-1:0] s_resetCountReg;
  logic                          s_released;

  assign s_released = s_resetCountReg[`RESET_COUNT_WIDTH-1];

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (!s_released) begin
      s_resetCountReg <= s_resetCountReg + 1'b1; // saturates once the top bit is set.
    end
  end

  assign systemReset      = ~s_released;
  assign peripheralResetN = s_released;
  assign ciReset          = ~s_released | memoryInitBusy; // held while memory initialises.

endmodule

`default_nettype wire

//--- hdl/swapByteIse.sv
`timescale 1ns/100ps
`default_nettype none

module swapByteIse import ciPkg::*; (
  input wire         ciStart,
  input wire ciIdE   ciN,
  input wire ciWordT ciValueA,
  input wire ciWordT ciValueB,
  output logic       ciDone,
  output ciWordT     ciResult
);

  logic     s_selected;
  swapModeE s_mode;
  ciWordT   s_swapped;

  assign s_selected = ciStart && (ciN == swapByteId);
  assign s_mode     = swapModeE'(ciValueB[0]);

  always_comb begin
    case (s_mode)
      halfwordSwap: s_swapped = {ciValueA[23:16], ciValueA[31:24], ciValueA[7:0], ciValueA[15:8]};
      default:      s_swapped = {ciValueA[7:0], ciValueA[15:8], ciValueA[23:16], ciValueA[31:24]};
    endcase
  end

  assign ciDone   = s_selected;
  assign ciResult = s_selected ? s_swapped : '0; // keeps the OR-combined result bus quiet.

endmodule

`default_nettype wire

//--- hdl/rgb565GrayscaleIse.sv
`timescale 1ns/100ps
`default_nettype none

`include "or1420Ci_params.svh"

module rgb565GrayscaleIse import ciPkg::*; (
  input wire         ciStart,
  input wire ciIdE   ciN,
  input wire ciWordT ciValueA,
  output logic       ciDone,
  output ciWordT     ciResult
);

  logic        s_selected;
  logic [7:0]  s_red;
  logic [7:0]  s_green;
  logic [7:0]  s_blue;
  logic [15:0] s_luma;

  assign s_selected = ciStart && (ciN == grayscaleId);

  // channels are widened by repeating their top bits, so full scale maps to 255.
  assign s_red   = {ciValueA[15:11], ciValueA[15:13]};
  assign s_green = {ciValueA[10:5], ciValueA[10:9]};
  assign s_blue  = {ciValueA[4:0], ciValueA[4:2]};

  // the weights add up to 256, so the sum never exceeds sixteen bits.
  assign s_luma = 16'd54 * s_red + 16'd183 * s_green + 16'd19 * s_blue;

  assign ciDone   = s_selected;
  assign ciResult = s_selected ? {{(`CI_WORD_WIDTH-8){1'b0}}, s_luma[15:8]} : '0;

endmodule

`default_nettype wire

//--- hdl/profileCounters.sv
`timescale 1ns/100ps
`default_nettype none

`include "or1420Ci_params.svh"

module profileCounters import ciPkg::*; import profilePkg::*; (
  input wire         s_systemClock,
  input wire         ciReset,
  input wire         ciStart,
  input wire         cpuStalled,
  input wire         busIdle,
  input wire ciIdE   ciN,
  input wire ciWordT ciValueA,
  input wire ciWordT ciValueB,
  output logic       ciDone,
  output ciWordT     ciResult
);

  ciWordT [`PROFILE_COUNTERS-1:0] s_counterReg;
  logic   [`PROFILE_COUNTERS-1:0] s_enableReg;
  logic   [`PROFILE_COUNTERS-1:0] s_countCondition;
  logic                           s_selected;
  profCtrlT                       s_control;
  profCounterE                    s_readSelect;

  assign s_selected   = ciStart && (ciN == profileId);
  assign s_control    = profCtrlT'(ciValueB[$bits(profCtrlT)-1:0]);
  assign s_readSelect = profCounterE'(ciValueA[1:0]);

  always_comb begin
    s_countCondition[totalCycles]   = 1'b1;
    s_countCondition[stallCycles]   = cpuStalled;
    s_countCondition[busIdleCycles] = busIdle;
    s_countCondition[activeCycles]  = ~cpuStalled;
  end

  // enable wins over disable when both bits are set for one counter.
  always_ff @(posedge s_systemClock or posedge ciReset) begin
    if (ciReset) begin
      s_enableReg <= '0;
    end else if (s_selected) begin
      s_enableReg <= (s_enableReg & ~s_control.disableMask) | s_control.enableMask;
    end
  end

  always_ff @(posedge s_systemClock or posedge ciReset) begin
    if (ciReset) begin
      s_counterReg <= '0;
    end else begin
      for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
        if (s_selected && s_control.clearMask[i]) begin
          s_counterReg[i] <= '0; // a clear overrides a pending increment.
        end else if (s_enableReg[i] && s_countCondition[i]) begin
          s_counterReg[i] <= s_counterReg[i] + 1'b1;
        end
      end
    end
  end

  // The read returns the count from before the edge that applies the control.
  assign ciDone   = s_selected;
  assign ciResult = s_selected ? s_counterReg[s_readSelect] : '0;

endmodule

`default_nettype wire

//--- hdl/or1420CiSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module or1420CiSubsystem import ciPkg::*; (
  input wire         s_systemClock,
  input wire         s_pllLocked,
  input wire         memoryInitBusy,
  input wire         ciStart,
  input wire         cpuStalled,
  input wire         busIdle,
  input wire ciIdE   ciN,
  input wire ciWordT ciValueA,
  input wire ciWordT ciValueB,
  output logic       systemReset,
  output logic       peripheralResetN,
  output logic       ciDone,
  output ciWordT     ciResult
);

  logic   s_ciReset;
  logic   s_swapByteDone;
  logic   s_grayscaleDone;
  logic   s_profileDone;
  ciWordT s_swapByteResult;
  ciWordT s_grayscaleResult;
  ciWordT s_profileResult;

  resetSequencer u_resetSequencer (
    .s_systemClock   (s_systemClock),
    .s_pllLocked     (s_pllLocked),
    .memoryInitBusy  (memoryInitBusy),
    .systemReset     (systemReset),
    .peripheralResetN(peripheralResetN),
    .ciReset         (s_ciReset)
  );

  swapByteIse u_swapByteIse (
    .ciStart (ciStart),
    .ciN     (ciN),
    .ciValueA(ciValueA),
    .ciValueB(ciValueB),
    .ciDone  (s_swapByteDone),
    .ciResult(s_swapByteResult)
  );

  rgb565GrayscaleIse u_rgb565GrayscaleIse (
    .ciStart (ciStart),
    .ciN     (ciN),
    .ciValueA(ciValueA),
    .ciDone  (s_grayscaleDone),
    .ciResult(s_grayscaleResult)
  );

  profileCounters u_profileCounters (
    .s_systemClock(s_systemClock),
    .ciReset      (s_ciReset),
    .ciStart      (ciStart),
    .cpuStalled   (cpuStalled),
    .busIdle      (busIdle),
    .ciN          (ciN),
    .ciValueA     (ciValueA),
    .ciValueB     (ciValueB),
    .ciDone       (s_profileDone),
    .ciResult     (s_profileResult)
  );

  // every instruction drives zero unless selected, so a plain OR merges them.
  assign ciDone   = s_swapByteDone | s_grayscaleDone | s_profileDone;
  assign ciResult = s_swapByteResult | s_grayscaleResult | s_profileResult;

endmodule

`default_nettype wire

//--- verification/tbOr1420Ci.sv
`timescale 1ns/100ps
`default_nettype none

module tbOr1420Ci import ciPkg::*; ();

  localparam int clockHalfPeriod   = 5;
  localparam int driveDelay        = 1;
  localparam int sampleDelay       = 8; // lands one ns before the next rising edge.
  localparam int lockHoldCycles    = 4;
  localparam int resetReleaseEdges = 16;
  localparam int resetTimeoutEdges = 40;
  localparam int maxTraceLines     = 1000;

  logic   s_systemClock;
  logic   s_pllLocked;
  logic   memoryInitBusy;
  logic   ciStart;
  logic   cpuStalled;
  logic   busIdle;
  ciIdE   ciN;
  ciWordT ciValueA;
  ciWordT ciValueB;
  logic   systemReset;
  logic   peripheralResetN;
  logic   ciDone;
  ciWordT ciResult;

  int    testCount      = 0;
  int    failedTests    = 0;
  int    checkCount     = 0;
  int    errorCount     = 0;
  int    testFirstError = 0;
  int    testFirstCheck = 0;
  bit    testOpen       = 1'b0;
  string testName       = "";
  string cycleContext   = "start";

  or1420CiSubsystem u_dut (
    .s_systemClock   (s_systemClock),
    .s_pllLocked     (s_pllLocked),
    .memoryInitBusy  (memoryInitBusy),
    .ciStart         (ciStart),
    .cpuStalled      (cpuStalled),
    .busIdle         (busIdle),
    .ciN             (ciN),
    .ciValueA        (ciValueA),
    .ciValueB        (ciValueB),
    .systemReset     (systemReset),
    .peripheralResetN(peripheralResetN),
    .ciDone          (ciDone),
    .ciResult        (ciResult)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(clockHalfPeriod) s_systemClock = ~s_systemClock;
  end

  task automatic compareValue(input string signalName, input logic [31:0] actual,
                              input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("mismatch %s: got 0x%08h, expected 0x%08h at %s", signalName, actual, expected,
               cycleContext);
    end
  endtask

  task automatic reportFailure(input string what);
    errorCount++;
    $display("error: %s", what);
  endtask

  task automatic startTest(input string name);
    testName       = name;
    testOpen       = 1'b1;
    testFirstError = errorCount;
    testFirstCheck = checkCount;
  endtask

  task automatic finishTest();
    int errors;
    int checks;
    errors = errorCount - testFirstError;
    checks = checkCount - testFirstCheck;
    if (testOpen) begin
      testCount++;
      if (errors == 0) begin
        $display("test %s: passed, %0d checks", testName, checks);
      end else begin
        failedTests++;
        $display("test %s: failed, %0d errors in %0d checks", testName, errors, checks);
      end
      testOpen = 1'b0;
    end
  endtask

  // counts the clock edges between lock and the release of peripheralResetN.
  task automatic checkResetSequence();
    int edgeCount;
    bit released;
    edgeCount = 0;
    released  = 1'b0;
    startTest("resetSequencing");
    for (int i = 0; i < lockHoldCycles; i++) begin
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      cycleContext = $sformatf("lock low cycle %0d", i);
      compareValue("systemReset", systemReset, 1);
      compareValue("peripheralResetN", peripheralResetN, 0);
    end
    @(posedge s_systemClock);
    #(driveDelay) s_pllLocked = 1'b1;
    while (!released && edgeCount < resetTimeoutEdges) begin
      @(posedge s_systemClock);
      edgeCount++;
      @(negedge s_systemClock);
      cycleContext = $sformatf("edge %0d after lock", edgeCount);
      if (peripheralResetN) begin
        released = 1'b1;
      end else begin
        compareValue("systemReset", systemReset, 1);
      end
    end
    if (!released) begin
      reportFailure($sformatf("peripheralResetN did not rise within %0d edges after lock",
                              resetTimeoutEdges));
    end else begin
      compareValue("releaseEdge", edgeCount, resetReleaseEdges);
      compareValue("systemReset", systemReset, 0);
    end
    finishTest();
  endtask

  task automatic driveCycle(input logic [31:0] start, input logic [31:0] idValue,
                            input logic [31:0] valueA, input logic [31:0] valueB,
                            input logic [31:0] initBusy, input logic [31:0] stalled,
                            input logic [31:0] idle, input logic [31:0] expDone,
                            input logic [31:0] expResult);
    @(posedge s_systemClock);
    #(driveDelay);
    ciStart        = start[0];
    ciN            = ciIdE'(idValue[7:0]); // the trace also drives numbers no instruction uses.
    ciValueA       = valueA;
    ciValueB       = valueB;
    memoryInitBusy = initBusy[0];
    cpuStalled     = stalled[0];
    busIdle        = idle[0];
    #(sampleDelay);
    compareValue("ciDone", ciDone, expDone);
    compareValue("ciResult", ciResult, expResult);
  endtask

  task automatic replayTrace();
    int          fd;
    int          lineNumber;
    int          fields;
    string       line;
    string       name;
    logic [31:0] start, idValue, valueA, valueB, initBusy, stalled, idle, expDone, expResult;
    lineNumber = 0;
    fd = $fopen("verification/ciTrace.txt", "r");
    if (fd == 0) begin
      reportFailure("cannot open the trace file verification/ciTrace.txt");
      return;
    end
    while (!$feof(fd) && lineNumber < maxTraceLines) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      lineNumber++;
      if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n" ||
          line.getc(0) == "\r") continue;
      if (line.getc(0) == "=") begin
        finishTest(); // a marker line closes the running test.
        name = "unnamed";
        fields = $sscanf(line, "= %s", name);
        startTest(name);
        continue;
      end
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", start, idValue, valueA, valueB,
                       initBusy, stalled, idle, expDone, expResult);
      if (fields != 9) begin
        reportFailure($sformatf("trace line %0d does not hold nine fields", lineNumber));
        continue;
      end
      cycleContext = $sformatf("trace line %0d", lineNumber);
      driveCycle(start, idValue, valueA, valueB, initBusy, stalled, idle, expDone, expResult);
    end
    if (!$feof(fd) && lineNumber >= maxTraceLines) begin
      reportFailure($sformatf("trace has more than %0d lines", maxTraceLines));
    end
    finishTest();
    $fclose(fd);
  endtask

  initial begin
    s_pllLocked    = 1'b0;
    memoryInitBusy = 1'b0;
    ciStart        = 1'b0;
    cpuStalled     = 1'b0;
    busIdle        = 1'b0;
    ciN            = ciIdE'(8'h00);
    ciValueA       = '0;
    ciValueB       = '0;
    checkResetSequence();
    replayTrace();
    if (checkCount == 0) begin
      reportFailure("no checks were run");
    end
    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d", testCount, failedTests,
             checkCount, errorCount);
    if (errorCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/ciTrace.txt
# columns (hex): start ciN valueA valueB memoryInitBusy cpuStalled busIdle expDone expResult
# a line starting with = names the test whose cycles follow, one cycle per line.
= byteSwap
1 01 11223344 00000000 0 0 0 1 44332211
1 01 11223344 00000001 0 0 0 1 22114433
0 01 11223344 00000001 0 0 0 0 00000000
1 01 A1B2C3D4 00000000 0 0 0 1 D4C3B2A1
1 01 A1B2C3D4 00000003 0 0 0 1 B2A1D4C3
= grayscale
1 0C 0000FFFF 00000000 0 0 0 1 000000FF
1 0C 00000000 00000000 0 0 0 1 00000000
1 0C 0000F800 00000000 0 0 0 1 00000035
1 0C 000007E0 00000000 0 0 0 1 000000B6
1 0C 0000001F 00000000 0 0 0 1 00000012
1 0C ABCDFFFF 00000000 0 0 0 1 000000FF
0 0C 0000FFFF 00000000 0 0 0 0 00000000
= quietBus
0 00 FFFFFFFF FFFFFFFF 0 0 0 0 00000000
1 05 FFFFFFFF FFFFFFFF 0 0 0 0 00000000
1 FF FFFFFFFF FFFFFFFF 0 0 0 0 00000000
1 00 12345678 00000001 0 0 0 0 00000000
0 0B 00000003 0000000F 0 0 0 0 00000000
= profileCount
1 0B 00000000 0000000F 0 0 0 1 00000000
0 00 00000000 00000000 0 0 0 0 00000000
0 00 00000000 00000000 0 1 0 0 00000000
0 00 00000000 00000000 0 1 1 0 00000000
0 00 00000000 00000000 0 0 1 0 00000000
0 00 00000000 00000000 0 0 1 0 00000000
0 00 00000000 00000000 0 1 0 0 00000000
0 00 00000000 00000000 0 0 0 0 00000000
0 00 00000000 00000000 0 0 1 0 00000000
1 0B 00000000 00000000 0 0 0 1 00000008
1 0B 00000001 00000000 0 1 0 1 00000003
1 0B 00000002 00000000 0 0 1 1 00000004
1 0B 00000003 00000000 0 0 0 1 00000007
1 0B 00000000 00000020 0 1 0 1 0000000C
0 00 00000000 00000000 0 1 1 0 00000000
1 0B 00000001 00000000 0 1 0 1 00000005
1 0B 00000000 00000122 0 0 0 1 0000000F
1 0B 00000000 00000000 0 1 0 1 00000000
1 0B 00000001 00000000 0 0 0 1 00000006
= memoryInit
0 00 00000000 00000000 1 0 0 0 00000000
1 0B 00000000 0000000F 1 0 0 1 00000000
1 01 11223344 00000000 1 1 1 1 44332211
0 00 00000000 00000000 1 1 1 0 00000000
0 00 00000000 00000000 0 0 0 0 00000000
1 0B 00000000 00000000 0 0 0 1 00000000
0 00 00000000 00000000 0 1 1 0 00000000
1 0B 00000003 00000000 0 0 0 1 00000000
1 0B 00000002 00000000 0 0 0 1 00000000

//--- src.f
+incdir+hdl
hdl/ciPkg.sv
hdl/profilePkg.sv
hdl/resetSequencer.sv
hdl/swapByteIse.sv
hdl/rgb565GrayscaleIse.sv
hdl/profileCounters.sv
hdl/or1420CiSubsystem.sv
verification/tbOr1420Ci.sv

//--- Bender.yml
package:
  name: or1420_ci

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ciPkg.sv
      - hdl/profilePkg.sv
      - hdl/resetSequencer.sv
      - hdl/swapByteIse.sv
      - hdl/rgb565GrayscaleIse.sv
      - hdl/profileCounters.sv
      - hdl/or1420CiSubsystem.sv
  - target: test
    files:
      - verification/tbOr1420Ci.sv
